/* all.f */
design/mem_pkg.sv
design/ctrl_pkg.sv
design/dl_packer.sv
design/dl_fifo.sv
design/rom_load_ctrl.sv
design/input_mapper.sv
design/arcade_shell_top.sv
test/arcade_shell_asserts.sv
test/tb_arcade_shell.sv

/* design/arcade_shell_top.sv */
module arcade_shell_top #(
	parameter int CPU_ROM_BYTES = 28672,
	parameter int GFX_ROM_BYTES = 32768,
	parameter int FIFO_DEPTH    = 8
) (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  mem_pkg::dl_port_t    dl,
	input  logic                 reset_req,
	input  logic                 key_strobe,
	input  logic                 key_pressed,
	input  logic [7:0]           key_code,
	input  ctrl_pkg::joy_t       joy0,
	input  ctrl_pkg::joy_t       joy1,
	input  logic                 rotate,
	input  logic                 flip,
	output mem_pkg::apb_req_t    apb_req,
	input  mem_pkg::apb_rsp_t    apb_rsp,
	output ctrl_pkg::game_ctrl_t ctrl,
	output logic                 core_reset,
	output logic                 load_error,
	output logic                 dl_overflow
);

	logic               push;
	logic               pop;
	logic               full;
	logic               empty;
	mem_pkg::wr_entry_t pack_entry;
	mem_pkg::wr_entry_t head_entry;

	dl_packer #(
		.CPU_ROM_BYTES (CPU_ROM_BYTES),
		.GFX_ROM_BYTES (GFX_ROM_BYTES)
	) u_packer (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl          (dl),
		.full        (full),
		.push        (push),
		.entry       (pack_entry),
		.dl_overflow (dl_overflow)
	);

	dl_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.push      (push),
		.entry_in  (pack_entry),
		.pop       (pop),
		.entry_out (head_entry),
		.full      (full),
		.empty     (empty)
	);

	rom_load_ctrl u_load (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl_active  (dl.active),
		.reset_req  (reset_req),
		.entry      (head_entry),
		.empty      (empty),
		.pop        (pop),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.load_error (load_error),
		.core_reset (core_reset)
	);

	input_mapper u_input (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joy0        (joy0),
		.joy1        (joy1),
		.rotate      (rotate),
		.flip        (flip),
		.ctrl        (ctrl)
	);

endmodule

/* design/ctrl_pkg.sv */
package ctrl_pkg;

	// PS/2 set 2 codes
	typedef enum logic [7:0] {
		up    = 8'h75,
		down  = 8'h72,
		left  = 8'h6b,
		right = 8'h74,
		esc   = 8'h76, // Coin
		f1    = 8'h05, // Start 1
		f2    = 8'h06, // Start 2
		space = 8'h29  // Fire
	} scancode_e;

	// Right sits at bit 0, fire at bit 4
	typedef struct packed {
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic start1;
		logic start2;
		logic coin;
	} game_ctrl_t;

endpackage

/* design/dl_fifo.sv */
module dl_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  logic               push,
	input  mem_pkg::wr_entry_t entry_in,
	input  logic               pop,
	output mem_pkg::wr_entry_t entry_out,
	output logic               full,
	output logic               empty
);

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = AW + 1;

	mem_pkg::wr_entry_t mem [FIFO_DEPTH];
	logic [AW-1:0]      wr_ptr;
	logic [AW-1:0]      rd_ptr;
	logic [CW-1:0]      count;
	logic               do_push;
	logic               do_pop;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
		if (p == AW'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full    = (count == CW'(FIFO_DEPTH));
	assign empty   = (count == '0);
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	assign entry_out = mem[rd_ptr]; // Head visible without a pop

	always_ff @(posedge clk_sys) begin
		if (do_push)
			mem[wr_ptr] <= entry_in;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

/* design/dl_packer.sv */
module dl_packer #(
	parameter int CPU_ROM_BYTES = 28672,
	parameter int GFX_ROM_BYTES = 32768
) (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  mem_pkg::dl_port_t   dl,
	input  logic                full,
	output logic                push,
	output mem_pkg::wr_entry_t  entry,
	output logic                dl_overflow
);

	localparam logic [mem_pkg::DL_ADDR_W-1:0] CPU_END = mem_pkg::DL_ADDR_W'(CPU_ROM_BYTES);
	localparam logic [mem_pkg::DL_ADDR_W-1:0] ALL_END =
		mem_pkg::DL_ADDR_W'(CPU_ROM_BYTES + GFX_ROM_BYTES);

	logic                          wr_q;
	logic                          rise_q;
	logic [mem_pkg::DL_ADDR_W-1:0] addr_q;
	logic [7:0]                    byte_q;
	logic                          hit;
	mem_pkg::rom_region_e          region;
	logic [mem_pkg::DL_ADDR_W-1:0] offset;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_q   <= 1'b0;
			rise_q <= 1'b0;
		end else begin
			wr_q   <= dl.wr;
			rise_q <= dl.active & dl.wr & ~wr_q; // Strobe edge inside download
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_q <= dl.addr;
		byte_q <= dl.data;
	end

	// Region decode
	always_comb begin
		hit    = 1'b1;
		region = mem_pkg::cpu_rom;
		offset = addr_q;
		if (addr_q < CPU_END) begin
			region = mem_pkg::cpu_rom;
		end else if (addr_q < ALL_END) begin
			region = mem_pkg::gfx_rom;
			offset = addr_q - CPU_END;
		end else begin
			hit = 1'b0; // Past both regions
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			push        <= 1'b0;
			dl_overflow <= 1'b0;
		end else begin
			push <= rise_q & hit & ~full;
			if (rise_q && hit && full)
				dl_overflow <= 1'b1; // Byte lost
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rise_q) begin
			entry.region    <= region;
			entry.word_addr <= offset[16:1];
			entry.data      <= {byte_q, byte_q};
			entry.strb      <= offset[0] ? 2'b10 : 2'b01; // Odd byte on upper lane
		end
	end

endmodule

/* design/input_mapper.sv */
module input_mapper (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  logic                 key_strobe,
	input  logic                 key_pressed,
	input  logic [7:0]           key_code,
	input  ctrl_pkg::joy_t       joy0,
	input  ctrl_pkg::joy_t       joy1,
	input  logic                 rotate,
	input  logic                 flip,
	output ctrl_pkg::game_ctrl_t ctrl
);

	ctrl_pkg::game_ctrl_t keys;
	logic                 m_up;
	logic                 m_down;
	logic                 m_left;
	logic                 m_right;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			keys <= '0;
		end else if (key_strobe) begin
			case (key_code)
				ctrl_pkg::up:    keys.up     <= key_pressed;
				ctrl_pkg::down:  keys.down   <= key_pressed;
				ctrl_pkg::left:  keys.left   <= key_pressed;
				ctrl_pkg::right: keys.right  <= key_pressed;
				ctrl_pkg::esc:   keys.coin   <= key_pressed;
				ctrl_pkg::f1:    keys.start1 <= key_pressed;
				ctrl_pkg::f2:    keys.start2 <= key_pressed;
				ctrl_pkg::space: keys.fire   <= key_pressed;
				default: ; // Other keys ignored
			endcase
		end
	end

	// Key plus both sticks
	assign m_up    = keys.up    | joy0.up    | joy1.up;
	assign m_down  = keys.down  | joy0.down  | joy1.down;
	assign m_left  = keys.left  | joy0.left  | joy1.left;
	assign m_right = keys.right | joy0.right | joy1.right;

	always_comb begin
		ctrl = keys;
		if (rotate) begin
			ctrl.up    = m_up;
			ctrl.down  = m_down;
			ctrl.left  = m_left;
			ctrl.right = m_right;
		end else if (flip) begin
			ctrl.up    = m_left;
			ctrl.down  = m_right;
			ctrl.left  = m_down;
			ctrl.right = m_up;
		end else begin
			// Quarter turn for the vertical monitor
			ctrl.up    = m_right;
			ctrl.down  = m_left;
			ctrl.left  = m_up;
			ctrl.right = m_down;
		end
		ctrl.fire = keys.fire | joy0.fire | joy1.fire;
	end

endmodule

/* design/mem_pkg.sv */
package mem_pkg;

	localparam int DL_ADDR_W = 24;
	localparam int WORD_W    = 16;
	localparam int PADDR_W   = 18; // Region bit, word address, byte bit

	typedef enum logic [0:0] {
		cpu_rom = 1'b0,
		gfx_rom = 1'b1
	} rom_region_e;

	typedef struct packed {
		rom_region_e       region;
		logic [WORD_W-1:0] word_addr; // Byte offset in region, halved
		logic [WORD_W-1:0] data;      // Same byte on both lanes
		logic [1:0]        strb;
	} wr_entry_t;

	typedef struct packed {
		logic                 active;
		logic                 wr;
		logic [DL_ADDR_W-1:0] addr;
		logic [7:0]           data;
	} dl_port_t;

	typedef struct packed {
		logic               psel;
		logic               penable;
		logic               pwrite;
		logic [PADDR_W-1:0] paddr;
		logic [WORD_W-1:0]  pwdata;
		logic [1:0]         pstrb;
	} apb_req_t;

	typedef struct packed {
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef enum logic [1:0] {
		idle   = 2'd0,
		setup  = 2'd1,
		access = 2'd2
	} apb_state_e;

endpackage

/* design/rom_load_ctrl.sv */
module rom_load_ctrl (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  logic               dl_active,
	input  logic               reset_req,
	input  mem_pkg::wr_entry_t entry,
	input  logic               empty,
	output logic               pop,
	output mem_pkg::apb_req_t  apb_req,
	input  mem_pkg::apb_rsp_t  apb_rsp,
	output logic               load_error,
	output logic               core_reset
);

	mem_pkg::apb_state_e state;
	mem_pkg::wr_entry_t  entry_q;
	logic [1:0]          active_q;
	logic                seen_fall;
	logic                rom_loaded;
	logic                dl_rise;

	assign pop     = (state == mem_pkg::idle) & ~empty;
	assign dl_rise = dl_active & ~active_q[0];

	always_comb begin
		apb_req         = '0;
		apb_req.psel    = (state != mem_pkg::idle);
		apb_req.penable = (state == mem_pkg::access);
		apb_req.pwrite  = (state != mem_pkg::idle);
		apb_req.paddr   = {entry_q.region, entry_q.word_addr, 1'b0};
		apb_req.pwdata  = entry_q.data;
		apb_req.pstrb   = entry_q.strb;
	end

	always_ff @(posedge clk_sys) begin
		if (pop)
			entry_q <= entry; // Held until completion
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state      <= mem_pkg::idle;
			load_error <= 1'b0;
		end else begin
			case (state)
				mem_pkg::idle:   if (pop) state <= mem_pkg::setup;
				mem_pkg::setup:  state <= mem_pkg::access;
				mem_pkg::access: begin
					if (apb_rsp.pready) begin
						state <= mem_pkg::idle;
						if (apb_rsp.pslverr)
							load_error <= 1'b1;
					end
				end
				default:         state <= mem_pkg::idle;
			endcase
		end
	end

	// Fall seen one cycle late so the last packed byte reaches the FIFO first
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			active_q   <= 2'b00;
			seen_fall  <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			active_q <= {active_q[0], dl_active};
			if (dl_rise) begin
				seen_fall  <= 1'b0;
				rom_loaded <= 1'b0;
			end else begin
				if (active_q[1] && !active_q[0])
					seen_fall <= 1'b1;
				if (seen_fall && empty && state == mem_pkg::idle)
					rom_loaded <= 1'b1;
			end
			core_reset <= reset_req | ~rom_loaded;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_arcade_shell \
	-f all.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
exit 0

/* test/arcade_shell_asserts.sv */
module arcade_shell_asserts (
	input logic              clk_sys,
	input logic              arst_n,
	input mem_pkg::apb_req_t apb_req,
	input mem_pkg::apb_rsp_t apb_rsp,
	input logic              pop,
	input logic              empty,
	input logic              push,
	input logic              full
);
	timeunit 1ns;
	timeprecision 1ps;

	// Setup lasts exactly one cycle
	a_setup_access: assert property (@(posedge clk_sys) disable iff (!arst_n)
		apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable)
		else $error("APB setup phase not followed by access phase");

	a_req_stable: assert property (@(posedge clk_sys) disable iff (!arst_n)
		apb_req.psel && !(apb_req.penable && apb_rsp.pready) |=>
			$stable(apb_req.paddr) && $stable(apb_req.pwdata) && $stable(apb_req.pstrb))
		else $error("APB request changed before completion");

	a_no_pop_empty: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(pop && empty)) else $error("FIFO popped while empty");

	a_no_push_full: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(push && full)) else $error("FIFO pushed while full");

endmodule

/* test/tb_arcade_shell.sv */
module tb_arcade_shell;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int          CPU_BYTES  = 28672;
	localparam int          GFX_BYTES  = 32768;
	localparam int          FIFO_DEPTH = 8;
	localparam int          TIMEOUT    = 2000;
	localparam logic [31:0] SEED       = 32'h262e9167;

	typedef struct packed {
		logic [17:0] paddr;
		logic [15:0] pwdata;
		logic [1:0]  pstrb;
	} apb_wr_t;

	typedef struct packed {
		logic [7:0]     code;
		logic           pressed;
		ctrl_pkg::joy_t j0;
		ctrl_pkg::joy_t j1;
		logic           rot;
		logic           flip;
		logic [7:0]     exp;
	} key_row_t;

	// Byte address, data
	localparam logic [31:0] DL_TAB [10] = '{
		{24'd0, 8'h3c},
		{24'd1, 8'ha5},
		{24'd2, 8'h0f},
		{24'd3, 8'hf0},
		{24'd28671, 8'h5a}, // Last CPU byte
		{24'd28672, 8'h11},
		{24'd28673, 8'h22},
		{24'd61439, 8'h33}, // Last GFX byte
		{24'd61440, 8'h44},
		{24'h100000, 8'h55}
	};

	// Expected word is up down left right fire start1 start2 coin
	localparam key_row_t KEY_TAB [12] = '{
		'{ctrl_pkg::up, 1'b1, 5'b00000, 5'b00000, 1'b1, 1'b0, 8'h80},
		'{8'h1c, 1'b1, 5'b00000, 5'b00000, 1'b1, 1'b0, 8'h80},
		'{ctrl_pkg::up, 1'b0, 5'b00000, 5'b00000, 1'b1, 1'b0, 8'h00},
		'{ctrl_pkg::right, 1'b1, 5'b00000, 5'b00000, 1'b0, 1'b0, 8'h80},
		'{8'h1c, 1'b0, 5'b00000, 5'b00000, 1'b0, 1'b1, 8'h40},
		'{ctrl_pkg::right, 1'b0, 5'b01000, 5'b00000, 1'b0, 1'b1, 8'h10},
		'{ctrl_pkg::space, 1'b1, 5'b00000, 5'b00010, 1'b1, 1'b0, 8'h28},
		'{ctrl_pkg::f1, 1'b1, 5'b10000, 5'b00100, 1'b0, 1'b0, 8'h1c},
		'{ctrl_pkg::f2, 1'b1, 5'b00000, 5'b00000, 1'b1, 1'b0, 8'h0e},
		'{ctrl_pkg::esc, 1'b1, 5'b00000, 5'b00000, 1'b1, 1'b0, 8'h0f},
		'{ctrl_pkg::space, 1'b0, 5'b00000, 5'b00000, 1'b1, 1'b0, 8'h07},
		'{8'h00, 1'b0, 5'b00001, 5'b01000, 1'b1, 1'b1, 8'h97}
	};

	logic                 clk_sys;
	logic                 arst_n;
	mem_pkg::dl_port_t    dl;
	logic                 reset_req;
	logic                 key_strobe;
	logic                 key_pressed;
	logic [7:0]           key_code;
	ctrl_pkg::joy_t       joy0;
	ctrl_pkg::joy_t       joy1;
	logic                 rotate;
	logic                 flip;
	mem_pkg::apb_req_t    apb_req;
	mem_pkg::apb_rsp_t    apb_rsp;
	ctrl_pkg::game_ctrl_t ctrl;
	logic                 core_reset;
	logic                 load_error;
	logic                 dl_overflow;

	apb_wr_t    exp_q [$];
	logic [1:0] wait_tab [256];
	logic       err_tab [256];
	logic [7:0] slot;
	int         wait_left;
	logic       hold_bus;
	logic       err_mode;
	logic       err_sent;
	int         errors;
	int         n_done;
	int         n_err;
	int         n_exp;
	int         n_tests;
	int         n_pass;
	int         err_mark;
	string      test_name;

	arcade_shell_top #(
		.CPU_ROM_BYTES (CPU_BYTES),
		.GFX_ROM_BYTES (GFX_BYTES),
		.FIFO_DEPTH    (FIFO_DEPTH)
	) dut (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl          (dl),
		.reset_req   (reset_req),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joy0        (joy0),
		.joy1        (joy1),
		.rotate      (rotate),
		.flip        (flip),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.ctrl        (ctrl),
		.core_reset  (core_reset),
		.load_error  (load_error),
		.dl_overflow (dl_overflow)
	);

	bind rom_load_ctrl arcade_shell_asserts u_apb_chk (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.pop     (pop),
		.empty   (empty),
		.push    (1'b0),
		.full    (1'b0)
	);

	bind dl_fifo arcade_shell_asserts u_fifo_chk (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.apb_req ('0),
		.apb_rsp ('0),
		.pop     (pop),
		.empty   (empty),
		.push    (push),
		.full    (full)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task check_val(input string what, input logic [35:0] exp, input logic [35:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s %s expected %0h actual %0h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task start_test(input string name);
		test_name = name;
		err_mark = errors;
	endtask

	task end_test();
		n_tests++;
		if (errors == err_mark) begin
			n_pass++;
			$display("%s: passed", test_name);
		end else begin
			$display("%s: failed", test_name);
		end
	endtask

	// Expected APB write from the region rules
	task queue_write(input logic [23:0] addr, input logic [7:0] data);
		apb_wr_t     e;
		int unsigned off;
		logic        region;
		if (addr < CPU_BYTES) begin
			region = 1'b0;
			off = addr;
		end else if (addr < CPU_BYTES + GFX_BYTES) begin
			region = 1'b1;
			off = addr - CPU_BYTES;
		end else begin
			return; // No write expected
		end
		e.paddr = {region, off[16:1], 1'b0};
		e.pwdata = {data, data};
		e.pstrb = off[0] ? 2'b10 : 2'b01;
		exp_q.push_back(e);
		n_exp++;
	endtask

	task send_byte(input logic [23:0] addr, input logic [7:0] data, input int gap,
			input bit keep);
		int i;
		if (keep)
			queue_write(addr, data);
		@(posedge clk_sys);
		dl.wr   <= 1'b1;
		dl.addr <= addr;
		dl.data <= data;
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		for (i = 0; i < gap; i++)
			@(posedge clk_sys);
	endtask

	task begin_download();
		@(posedge clk_sys);
		dl.active <= 1'b1;
	endtask

	task end_download();
		@(posedge clk_sys);
		dl.active <= 1'b0;
	endtask

	task wait_release();
		int n;
		n = 0;
		while (core_reset !== 1'b0 && n < TIMEOUT) begin
			@(posedge clk_sys);
			n++;
		end
		if (core_reset !== 1'b0) begin
			$display("%s: timed out waiting for core_reset to fall", test_name);
			errors++;
		end else begin
			check_val("writes pending at release", 0, exp_q.size());
		end
	endtask

	// APB memory with random wait states
	always @(posedge clk_sys) begin : apb_mem_model
		int   w;
		logic go;
		go = 1'b0;
		if (apb_req.psel && !apb_req.penable) begin
			w = hold_bus ? 1 : int'(wait_tab[slot]);
			slot <= slot + 8'd1;
			wait_left <= w;
			go = (w == 0);
		end else if (apb_req.psel && !apb_rsp.pready && !hold_bus) begin
			wait_left <= wait_left - 1;
			go = (wait_left <= 1);
		end
		if (apb_req.psel && apb_req.penable && apb_rsp.pready) begin
			apb_rsp <= '0; // Completion taken at this edge
		end else if (go) begin
			apb_rsp.pready  <= 1'b1;
			apb_rsp.pslverr <= err_mode & (err_tab[slot] | ~err_sent);
			if (err_mode)
				err_sent <= 1'b1;
		end
	end

	always @(posedge clk_sys) begin : apb_monitor
		apb_wr_t e;
		if (arst_n && apb_req.psel && apb_req.penable && apb_rsp.pready) begin
			n_done++;
			if (apb_rsp.pslverr)
				n_err++;
			if (exp_q.size() == 0) begin
				$display("%s: APB write to %h that no download byte asked for",
					test_name, apb_req.paddr);
				errors++;
			end else begin
				e = exp_q.pop_front();
				check_val("pwrite", 1, apb_req.pwrite);
				check_val("paddr", e.paddr, apb_req.paddr);
				check_val("pwdata", e.pwdata, apb_req.pwdata);
				check_val("pstrb", e.pstrb, apb_req.pstrb);
			end
		end
	end

	initial begin
		int          i;
		int          exp_mark;
		int          done_mark;
		logic [23:0] addr;
		void'($urandom(SEED));
		for (i = 0; i < 256; i++) begin
			wait_tab[i] = 2'($urandom % 4);
			err_tab[i] = 1'($urandom % 2);
		end
		arst_n = 1'b0;
		dl = '0;
		reset_req = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = 8'h00;
		joy0 = '0;
		joy1 = '0;
		rotate = 1'b1;
		flip = 1'b0;
		apb_rsp = '0;
		slot = 8'd0;
		wait_left = 0;
		hold_bus = 1'b0;
		err_mode = 1'b0;
		err_sent = 1'b0;
		errors = 0;
		n_done = 0;
		n_err = 0;
		n_exp = 0;
		n_tests = 0;
		n_pass = 0;
		repeat (10) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(posedge clk_sys);

		start_test("reset values");
		check_val("psel", 0, apb_req.psel);
		check_val("penable", 0, apb_req.penable);
		check_val("push", 0, dut.push);
		check_val("pop", 0, dut.pop);
		check_val("core_reset", 1, core_reset);
		check_val("dl_overflow", 0, dl_overflow);
		check_val("load_error", 0, load_error);
		check_val("ctrl", 0, ctrl);
		end_test();

		start_test("cpu region");
		begin_download();
		for (i = 0; i < 5; i++)
			send_byte(DL_TAB[i][31:8], DL_TAB[i][7:0], 6, 1'b1);
		end_download();
		wait_release();
		end_test();

		start_test("gfx region");
		exp_mark = n_exp;
		done_mark = n_done;
		begin_download();
		for (i = 5; i < 10; i++)
			send_byte(DL_TAB[i][31:8], DL_TAB[i][7:0], 6, 1'b1);
		end_download();
		wait_release();
		check_val("write count", n_exp - exp_mark, n_done - done_mark);
		end_test();

		start_test("stalls and overflow");
		begin_download();
		for (i = 0; i < 12; i++) begin
			addr = 24'($urandom % (CPU_BYTES + GFX_BYTES + 256));
			send_byte(addr, 8'($urandom), 6, 1'b1);
		end
		end_download();
		wait_release();
		check_val("dl_overflow before burst", 0, dl_overflow);
		@(posedge clk_sys);
		hold_bus <= 1'b1;
		begin_download();
		// One entry held by the master, the rest fill the FIFO
		for (i = 0; i < FIFO_DEPTH + 4; i++)
			send_byte(24'(100 + i), 8'(i), 0, i <= FIFO_DEPTH);
		check_val("dl_overflow after burst", 1, dl_overflow);
		@(posedge clk_sys);
		hold_bus <= 1'b0;
		end_download();
		wait_release();
		end_test();

		start_test("core reset");
		begin_download();
		for (i = 0; i < 3; i++) begin
			send_byte(24'(200 + i), 8'(8'hc0 + i), 2, 1'b1);
			check_val("core_reset in download", 1, core_reset);
		end
		end_download();
		check_val("core_reset after download", 1, core_reset);
		wait_release();
		@(posedge clk_sys);
		reset_req <= 1'b1;
		repeat (3) @(posedge clk_sys);
		check_val("core_reset on reset_req", 1, core_reset);
		reset_req <= 1'b0;
		wait_release();
		end_test();

		start_test("slave error");
		check_val("load_error before", 0, load_error);
		@(posedge clk_sys);
		err_mode <= 1'b1;
		begin_download();
		for (i = 0; i < 4; i++)
			send_byte(24'(300 + i), 8'($urandom), 6, 1'b1);
		end_download();
		wait_release();
		err_mode <= 1'b0;
		check_val("load_error", n_err > 0, load_error);
		begin_download();
		send_byte(24'd400, 8'h77, 6, 1'b1);
		end_download();
		wait_release();
		check_val("load_error sticky", 1, load_error);
		end_test();

		start_test("key table");
		for (i = 0; i < 12; i++) begin
			@(posedge clk_sys);
			key_strobe  <= 1'b1;
			key_code    <= KEY_TAB[i].code;
			key_pressed <= KEY_TAB[i].pressed;
			joy0        <= KEY_TAB[i].j0;
			joy1        <= KEY_TAB[i].j1;
			rotate      <= KEY_TAB[i].rot;
			flip        <= KEY_TAB[i].flip;
			@(posedge clk_sys);
			key_strobe <= 1'b0;
			@(negedge clk_sys);
			check_val($sformatf("ctrl row %0d", i), KEY_TAB[i].exp, ctrl);
		end
		end_test();

		$display("%0d of %0d tests passed, %0d errors", n_pass, n_tests, errors);
		if (errors == 0 && n_pass == n_tests) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
